// File: pcs_test_top.f
+incdir+rtl
rtl/pcs_test_pkg.sv
rtl/register_file.sv
rtl/cgmii_generator.sv
rtl/pcs_encoder.sv
rtl/bram_logger.sv
rtl/log_ram_arbiter.sv
rtl/pcs_test_top.sv
dv/tb_clock_gen.sv
dv/pcs_test_tb.sv

// File: dv/pcs_test_tb.sv
`timescale 1ns/1ps
`include "pcs_test_config.svh"

module pcs_test_tb
    import pcs_test_pkg::*;
();

    localparam int MAX_CYCLES     = 4000;
    localparam int READBACK_LIMIT = 16;
    localparam int MAX_POLLS      = 80;
    localparam int LOG_DEPTH      = 1 << `LOG_ADDR_BITS;

    logic       clock;
    logic       reset;
    logic       restart;
    gpio_word_t gpio_in;
    gpio_word_t gpio_out;
    logic       readback_valid;
    logic       en_cgmii;
    logic       en_encoder;
    logic       en_bram;

    logic [31:0] lfsr_state = 32'h12b7_a750;
    gpio_word_t  exp_value [$];     // expected readbacks in command order
    bit          exp_check [$];     // polling reads are not compared
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_errors;
    string       test_name;
    int          cycle_count;

    tb_clock_gen u_clock_gen
    (
        .i_restart (restart),
        .o_clock   (clock),
        .o_reset   (reset)
    );

    pcs_test_top i_dut
    (
        .i_clock          (clock),
        .i_reset          (reset),
        .i_gpio_in        (gpio_in),
        .o_gpio_out       (gpio_out),
        .o_readback_valid (readback_valid),
        .o_enable_cgmii   (en_cgmii),
        .o_enable_encoder (en_encoder),
        .o_enable_bram    (en_bram)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int unsigned value);
        int i;
        value = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    // encoded block expected at log index, built from the pattern rules
    function automatic enc_block_t ref_block(input int unsigned index);
        logic [31:0] seq;
        if (index % `IDLE_PERIOD == `IDLE_PERIOD - 1)
            return {2'b10, 56'd0, 8'h1e};
        seq = index - index / `IDLE_PERIOD;    // data blocks sent before this one
        return {2'b01, seq, ~seq};
    endfunction

    function automatic gpio_word_t ref_slice(input enc_block_t blk, input logic [1:0] sel);
        case (sel)
            2'd0:    return blk[31:0];
            2'd1:    return blk[63:32];
            default: return {30'd0, blk[65:64]};
        endcase
    endfunction

    function automatic gpio_word_t make_cmd(input opcode_t op, input logic [`DATA_LEN-1:0] data);
        return {1'b1, op, 2'b00, data};
    endfunction

    // compare every readback pulse with the oldest outstanding expectation
    always @(negedge clock)
    begin
        if (readback_valid)
        begin
            assert (exp_value.size() != 0)
            else
            begin
                $display("readback pulse at %0t with no command outstanding", $time);
                errors++;
            end
            if (exp_value.size() != 0)
            begin
                if (exp_check.pop_front())
                begin
                    checks++;
                    assert (gpio_out === exp_value[0])
                    else
                    begin
                        $display("error at %0t: o_gpio_out expected %h got %h",
                                 $time, exp_value[0], gpio_out);
                        errors++;
                    end
                end
                void'(exp_value.pop_front());
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic apply_reset();
        @(negedge clock);
        restart = 1'b1;
        @(negedge clock);
        restart = 1'b0;
        while (reset)
            @(negedge clock);
    endtask

    // command is held for exactly one rising edge
    task automatic issue(input gpio_word_t word);
        gpio_in = word;
        @(negedge clock);
        gpio_in = '0;
    endtask

    task automatic random_gap();
        int unsigned gap;
        draw_bits(2, gap);
        repeat (gap) @(negedge clock);
    endtask

    task automatic transact(input gpio_word_t word, input bit check, input gpio_word_t want,
                            output gpio_word_t got);
        int waited;
        exp_value.push_back(want);
        exp_check.push_back(check);
        issue(word);
        waited = 0;
        while (!readback_valid && waited < READBACK_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        assert (readback_valid)
        else
        begin
            $display("no readback pulse within %0d cycles of command %h", READBACK_LIMIT, word);
            errors++;
        end
        got = gpio_out;
        random_gap();
    endtask

    task automatic read_count(output gpio_word_t count);
        transact(make_cmd(OP_COUNT, '0), 1'b0, '0, count);
    endtask

    task automatic expect_count(input int want);
        gpio_word_t got;
        transact(make_cmd(OP_COUNT, '0), 1'b1, gpio_word_t'(want), got);
    endtask

    task automatic read_slice(input log_addr_t addr, input logic [1:0] sel);
        gpio_word_t got;
        transact(make_cmd(OP_READ, {10'd0, sel, 2'b00, addr}), 1'b1,
                 ref_slice(ref_block(addr), sel), got);
    endtask

    task automatic check_enables(input logic [2:0] want);
        checks++;
        assert ({en_bram, en_encoder, en_cgmii} === want)
        else
        begin
            $display("error at %0t: enables {bram,encoder,cgmii} expected %b got %b",
                     $time, want, {en_bram, en_encoder, en_cgmii});
            errors++;
        end
    endtask

    // bit 0 generator, bit 1 encoder, bit 2 logger
    task automatic set_enables(input logic [2:0] value);
        issue(make_cmd(OP_ENABLE, {17'd0, value}));
        check_enables(value);
        random_gap();
    endtask

    task automatic wait_for_full();
        gpio_word_t count;
        int polls;
        polls = 0;
        count = '0;
        while (count != LOG_DEPTH && polls < MAX_POLLS)
        begin
            repeat (4) @(negedge clock);
            read_count(count);
            polls++;
        end
        assert (count == LOG_DEPTH)
        else
        begin
            $display("log did not fill within %0d count polls", polls);
            errors++;
        end
    endtask

    task automatic check_log(input int depth);
        int a;
        int s;
        for (a = 0; a < depth; a++)
            for (s = 0; s < 3; s++)
                read_slice(log_addr_t'(a), s[1:0]);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        @(negedge clock);   // let the compare process see the last pulse
        tests++;
        if (errors != test_errors)
            failed_tests++;
        $display("test %0d %-22s %s", tests, test_name,
                 (errors == test_errors) ? "ok" : "had errors");
    endtask

    task automatic test_read_during_logging();
        gpio_word_t  count;
        int          prev;
        int          rounds;
        int unsigned pick;
        int          s;
        prev   = 0;
        rounds = 0;
        count  = '0;
        while (count < LOG_DEPTH && rounds < 30)
        begin
            read_count(count);
            checks++;
            assert (count <= LOG_DEPTH && count >= prev)
            else
            begin
                $display("error at %0t: log count expected %0d to %0d got %0d",
                         $time, prev, LOG_DEPTH, count);
                errors++;
            end
            if (count > 0)
            begin
                draw_bits(6, pick);
                for (s = 0; s < 3; s++)
                    read_slice(log_addr_t'(pick % count), s[1:0]);
            end
            prev = count;
            rounds++;
        end
    endtask

    initial
    begin
        gpio_in = '0;
        restart = 1'b0;
        @(negedge clock);
        while (reset)
            @(negedge clock);

        start_test("reset state");
        check_enables(3'b000);
        expect_count(0);
        end_test();

        start_test("enable decode");
        for (int v = 0; v < 8; v++)
            set_enables(v[2:0]);
        issue({1'b0, OP_ENABLE, 2'b00, 20'd2});    // strobe bit clear
        check_enables(3'b111);
        issue({1'b1, 9'h1a5, 2'b00, 20'd2});       // opcode not defined
        check_enables(3'b111);
        end_test();

        start_test("fill and hold");
        apply_reset();
        set_enables(3'b011);
        repeat (20) @(negedge clock);
        expect_count(0);
        expect_count(0);
        set_enables(3'b111);
        wait_for_full();
        repeat (20) @(negedge clock);
        expect_count(LOG_DEPTH);
        end_test();

        start_test("full readback");
        check_log(LOG_DEPTH);
        end_test();

        start_test("logger enabled first");
        apply_reset();
        set_enables(3'b100);
        repeat (10) @(negedge clock);
        expect_count(0);
        set_enables(3'b111);
        wait_for_full();
        check_log(LOG_DEPTH);
        end_test();

        start_test("reads while logging");
        apply_reset();
        set_enables(3'b111);
        test_read_during_logging();
        end_test();

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors, %0d cycles",
                 tests, failed_tests, checks, errors, cycle_count);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    input  logic i_restart,     // pulse to run the reset sequence again
    output logic o_clock,
    output logic o_reset
);

    localparam int RESET_CYCLES = 3;

    int unsigned reset_left = RESET_CYCLES;

    initial
        o_clock = 1'b0;

    always #4 o_clock = ~o_clock;   // 8 ns period

    always @(posedge o_clock)
    begin
        if (i_restart)
            reset_left <= RESET_CYCLES;
        else if (reset_left != 0)
            reset_left <= reset_left - 1;
    end

    assign o_reset = (reset_left != 0);

endmodule

// File: rtl/pcs_test_top.sv
`timescale 1ns/1ps

module pcs_test_top
    import pcs_test_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  gpio_word_t  i_gpio_in,
    output gpio_word_t  o_gpio_out,
    output logic        o_readback_valid,
    output logic        o_enable_cgmii,
    output logic        o_enable_encoder,
    output logic        o_enable_bram
);

    logic        gen_valid;
    logic        gen_ready;
    block_data_t gen_data;
    block_ctrl_t gen_ctrl;

    logic        enc_valid;
    logic        enc_ready;
    enc_block_t  enc_block;

    logic        wr_valid;
    logic        wr_ready;
    log_addr_t   wr_addr;
    enc_block_t  wr_block;

    logic        rd_valid;
    logic        rd_ready;
    log_addr_t   rd_addr;
    logic        rd_rsp_valid;
    enc_block_t  rd_rsp_block;

    log_count_t  log_count;

    register_file u_register_file
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_gpio_in        (i_gpio_in),
        .i_rd_ready       (rd_ready),
        .i_rd_rsp_valid   (rd_rsp_valid),
        .i_rd_rsp_block   (rd_rsp_block),
        .i_log_count      (log_count),
        .o_enable_cgmii   (o_enable_cgmii),
        .o_enable_encoder (o_enable_encoder),
        .o_enable_bram    (o_enable_bram),
        .o_rd_valid       (rd_valid),
        .o_rd_addr        (rd_addr),
        .o_gpio_out       (o_gpio_out),
        .o_readback_valid (o_readback_valid)
    );

    cgmii_generator u_cgmii_generator
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (o_enable_cgmii),
        .i_ready  (gen_ready),
        .o_valid  (gen_valid),
        .o_data   (gen_data),
        .o_ctrl   (gen_ctrl)
    );

    pcs_encoder u_pcs_encoder
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (o_enable_encoder),
        .i_valid  (gen_valid),
        .i_data   (gen_data),
        .i_ctrl   (gen_ctrl),
        .i_ready  (enc_ready),
        .o_ready  (gen_ready),
        .o_valid  (enc_valid),
        .o_block  (enc_block)
    );

    bram_logger u_bram_logger
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_enable    (o_enable_bram),
        .i_valid     (enc_valid),
        .i_block     (enc_block),
        .i_wr_ready  (wr_ready),
        .o_ready     (enc_ready),
        .o_wr_valid  (wr_valid),
        .o_wr_addr   (wr_addr),
        .o_wr_block  (wr_block),
        .o_log_count (log_count)
    );

    log_ram_arbiter u_log_ram_arbiter
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_wr_valid     (wr_valid),
        .i_wr_addr      (wr_addr),
        .i_wr_block     (wr_block),
        .i_rd_valid     (rd_valid),
        .i_rd_addr      (rd_addr),
        .o_wr_ready     (wr_ready),
        .o_rd_ready     (rd_ready),
        .o_rd_rsp_valid (rd_rsp_valid),
        .o_rd_rsp_block (rd_rsp_block)
    );

endmodule

// File: rtl/log_ram_arbiter.sv
`timescale 1ns/1ps
`include "pcs_test_config.svh"

module log_ram_arbiter
    import pcs_test_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_wr_valid,
    input  log_addr_t   i_wr_addr,
    input  enc_block_t  i_wr_block,
    input  logic        i_rd_valid,
    input  log_addr_t   i_rd_addr,
    output logic        o_wr_ready,
    output logic        o_rd_ready,
    output logic        o_rd_rsp_valid,
    output enc_block_t  o_rd_rsp_block
);

    localparam int DEPTH = 1 << `LOG_ADDR_BITS;

    enc_block_t mem [DEPTH];
    logic       rd_grant;
    logic       wr_grant;
    log_addr_t  ram_addr;

    // reads win and a write waits for a free cycle
    assign o_rd_ready = 1'b1;
    assign o_wr_ready = !i_rd_valid;

    assign rd_grant = i_rd_valid && o_rd_ready;
    assign wr_grant = i_wr_valid && o_wr_ready;

    assign ram_addr = rd_grant ? i_rd_addr : i_wr_addr;  // single shared address port

    always_ff @(posedge i_clock)
    begin
        if (wr_grant)
            mem[ram_addr] <= i_wr_block;
        if (rd_grant)
            o_rd_rsp_block <= mem[ram_addr];
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_rd_rsp_valid <= 1'b0;
        else
            o_rd_rsp_valid <= rd_grant;     // one-cycle pulse after the read
    end

    // a write held off by a read keeps its slot and data
    a_wr_hold: assert property (@(posedge i_clock) disable iff (i_reset)
        i_wr_valid && !o_wr_ready |=>
            i_wr_valid && $stable(i_wr_addr) && $stable(i_wr_block));

endmodule

// File: rtl/bram_logger.sv
`timescale 1ns/1ps
`include "pcs_test_config.svh"

module bram_logger
    import pcs_test_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_valid,
    input  enc_block_t  i_block,
    input  logic        i_wr_ready,
    output logic        o_ready,
    output logic        o_wr_valid,
    output log_addr_t   o_wr_addr,
    output enc_block_t  o_wr_block,
    output log_count_t  o_log_count
);

    localparam log_count_t LOG_DEPTH = log_count_t'(1 << `LOG_ADDR_BITS);

    logic full;
    logic accept;
    logic wr_done;

    assign full    = (o_log_count == LOG_DEPTH);
    assign o_ready = i_enable && !full && !o_wr_valid;
    assign accept  = i_valid && o_ready;
    assign wr_done = o_wr_valid && i_wr_ready;

    assign o_wr_addr = o_log_count[`LOG_ADDR_BITS-1:0];   // next free slot

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_wr_valid  <= 1'b0;
            o_log_count <= '0;
        end
        else
        begin
            if (accept)
                o_wr_valid <= 1'b1;
            else if (wr_done)
                o_wr_valid <= 1'b0;
            if (wr_done)
                o_log_count <= o_log_count + 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (accept)
            o_wr_block <= i_block;
    end

    a_count_max: assert property (@(posedge i_clock) disable iff (i_reset)
        o_log_count <= LOG_DEPTH);

endmodule

// File: rtl/pcs_encoder.sv
`timescale 1ns/1ps
`include "pcs_test_config.svh"

module pcs_encoder
    import pcs_test_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_valid,
    input  block_data_t i_data,
    input  block_ctrl_t i_ctrl,
    input  logic        i_ready,
    output logic        o_ready,
    output logic        o_valid,
    output enc_block_t  o_block
);

    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;
    localparam logic [7:0] TYPE_CTRL = 8'h1e;   // all-control block type

    logic       all_idle;
    logic       is_error;
    enc_block_t enc_next;
    logic       accept;

    assign all_idle = (i_ctrl == 8'hff) && (i_data == {8{8'h07}});
    assign is_error = (i_ctrl != 8'h00) && !all_idle;

    always_comb
    begin
        if (i_ctrl == 8'h00)
            enc_next = {SYNC_DATA, i_data};
        else if (all_idle)
            enc_next = {SYNC_CTRL, 56'd0, TYPE_CTRL};   // idle code is 7'h00
        else
            enc_next = {SYNC_CTRL, {8{7'h1e}}, TYPE_CTRL};
    end

    // take a new block when the output stage is empty or draining
    assign o_ready = i_enable && (!o_valid || i_ready);
    assign accept  = i_valid && o_ready;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else if (accept)
            o_valid <= 1'b1;
        else if (i_ready)
            o_valid <= 1'b0;    // output taken downstream
    end

    always_ff @(posedge i_clock)
    begin
        if (accept)
            o_block <= enc_next;
    end

    // generator only ever offers data or idle blocks
    a_no_error: assert property (@(posedge i_clock) disable iff (i_reset)
        i_valid |-> !is_error);

endmodule

// File: rtl/cgmii_generator.sv
`timescale 1ns/1ps
`include "pcs_test_config.svh"

module cgmii_generator
    import pcs_test_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_ready,
    output logic        o_valid,
    output block_data_t o_data,
    output block_ctrl_t o_ctrl
);

    localparam int PHASE_W = $clog2(`IDLE_PERIOD);

    logic [PHASE_W-1:0] phase;      // block index modulo IDLE_PERIOD
    logic [31:0]        seq;        // counts data blocks only
    logic               is_idle;
    logic               xfer;

    assign is_idle = (phase == PHASE_W'(`IDLE_PERIOD - 1));
    assign o_valid = i_enable;
    assign xfer    = o_valid && i_ready;

    always_comb
    begin
        if (is_idle)
        begin
            o_data = {8{8'h07}};    // eight idle characters
            o_ctrl = 8'hff;
        end
        else
        begin
            o_data = {seq, ~seq};
            o_ctrl = 8'h00;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            phase <= '0;
            seq   <= '0;
        end
        else if (xfer)
        begin
            phase <= is_idle ? '0 : phase + 1'b1;
            if (!is_idle)
                seq <= seq + 1'b1;
        end
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps
`include "pcs_test_config.svh"

module register_file
    import pcs_test_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  gpio_word_t  i_gpio_in,
    input  logic        i_rd_ready,
    input  logic        i_rd_rsp_valid,
    input  enc_block_t  i_rd_rsp_block,
    input  log_count_t  i_log_count,
    output logic        o_enable_cgmii,
    output logic        o_enable_encoder,
    output logic        o_enable_bram,
    output logic        o_rd_valid,
    output log_addr_t   o_rd_addr,
    output gpio_word_t  o_gpio_out,
    output logic        o_readback_valid
);

    localparam int CGMII_ENB_BIT   = 0;
    localparam int ENCODER_ENB_BIT = 1;
    localparam int BRAM_ENB_BIT    = 2;

    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_REQUEST,
        RD_WAIT_RSP
    } rd_state_t;

    logic                   cmd_en;
    opcode_t                opcode;
    logic [`DATA_LEN-1:0]   cmd_data;
    logic [`N_MODULES-1:0]  enable_reg;
    rd_state_t              state;
    logic [1:0]             slice_sel;
    gpio_word_t             rsp_slice;

    assign cmd_en   = i_gpio_in[`GPIO_LEN-1];   // command strobe in the top bit
    assign opcode   = opcode_t'(i_gpio_in[`GPIO_LEN-2 -: `OPCODE_LEN]);
    assign cmd_data = i_gpio_in[`DATA_LEN-1:0];

    assign o_enable_cgmii   = enable_reg[CGMII_ENB_BIT];
    assign o_enable_encoder = enable_reg[ENCODER_ENB_BIT];
    assign o_enable_bram    = enable_reg[BRAM_ENB_BIT];

    assign o_rd_valid = (state == RD_REQUEST);

    // pick the 32-bit view of the returned block
    always_comb
    begin
        case (slice_sel)
            2'd0:    rsp_slice = i_rd_rsp_block[31:0];
            2'd1:    rsp_slice = i_rd_rsp_block[63:32];
            2'd2:    rsp_slice = {30'd0, i_rd_rsp_block[65:64]};
            default: rsp_slice = '0;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            enable_reg       <= '0;
            state            <= RD_IDLE;
            o_gpio_out       <= '0;
            o_readback_valid <= 1'b0;
        end
        else
        begin
            o_readback_valid <= 1'b0;
            case (state)
                RD_IDLE:
                begin
                    if (cmd_en)
                    begin
                        case (opcode)
                            OP_ENABLE: enable_reg <= cmd_data[`N_MODULES-1:0];
                            OP_READ:
                            begin
                                o_rd_addr <= cmd_data[`LOG_ADDR_BITS-1:0];
                                slice_sel <= cmd_data[9:8];
                                state     <= RD_REQUEST;
                            end
                            OP_COUNT:
                            begin
                                o_gpio_out       <= gpio_word_t'(i_log_count);
                                o_readback_valid <= 1'b1;
                            end
                            default: ;  // unknown opcodes are ignored
                        endcase
                    end
                end
                RD_REQUEST:
                begin
                    if (i_rd_ready)
                        state <= RD_WAIT_RSP;
                end
                RD_WAIT_RSP:
                begin
                    if (i_rd_rsp_valid)
                    begin
                        o_gpio_out       <= rsp_slice;
                        o_readback_valid <= 1'b1;
                        state            <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // a RAM response only comes back while a read is outstanding
    a_rsp_expected: assert property (@(posedge i_clock) disable iff (i_reset)
        i_rd_rsp_valid |-> state == RD_WAIT_RSP);

endmodule

// File: rtl/pcs_test_pkg.sv
`include "pcs_test_config.svh"

package pcs_test_pkg;

    typedef logic [`GPIO_LEN-1:0]       gpio_word_t;

    // CGMII side of one 64-bit block
    typedef logic [63:0]                block_data_t;
    typedef logic [7:0]                 block_ctrl_t;   // one flag per byte

    // {sync header[1:0], payload[63:0]}
    typedef logic [65:0]                enc_block_t;

    typedef logic [`LOG_ADDR_BITS-1:0]  log_addr_t;
    typedef logic [`LOG_ADDR_BITS:0]    log_count_t;    // 0 to full depth inclusive

    // host command opcodes in GPIO bits 30:22
    typedef enum logic [`OPCODE_LEN-1:0]
    {
        OP_ENABLE = 9'h001,
        OP_READ   = 9'h002,
        OP_COUNT  = 9'h003
    } opcode_t;

endpackage

// File: rtl/pcs_test_config.svh
`ifndef PCS_TEST_CONFIG_SVH
`define PCS_TEST_CONFIG_SVH

// GPIO command word layout
`define GPIO_LEN        32
`define OPCODE_LEN      9
`define DATA_LEN        20

// enables driven by the register file (generator, encoder, logger)
`define N_MODULES       3

// log RAM holds 2**LOG_ADDR_BITS blocks
`define LOG_ADDR_BITS   6

// one idle block in every IDLE_PERIOD generated blocks
`define IDLE_PERIOD     5

`endif
